// ==== source/obj_pkg.sv ====
`default_nettype none

package obj_pkg;

    typedef logic [12:0] tile_code_t;
    typedef logic [11:0] coord_t;
    // 0 selects full size
    typedef logic [7:0]  zoom_t;
    typedef logic [7:0]  color_t;
    // {row[7:0], word column[6:0]}
    typedef logic [14:0] fb_word_addr_t;
    typedef logic [63:0] fb_word_t;
    typedef logic [7:0]  fb_be_t;
    typedef logic [31:0] mem_addr_t;
    typedef logic [7:0]  burst_len_t;

    localparam int TILE_SIZE = 16;
    // a drawn row spans up to 19 pixels, so five 4-pixel words
    localparam int ROW_WORDS = 5;

    localparam int MAX_X = 480;
    localparam int MAX_Y = 240;

    localparam int BURST_4BPP = 16;
    localparam int BURST_6BPP = 32;

    localparam mem_addr_t OBJ_DATA_BASE = 32'h0010_0000;
    localparam mem_addr_t OBJ_FB_BASE   = 32'h0080_0000;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CHECK,
        ST_ZOOM,
        ST_LOAD,
        ST_FB_LOAD,
        ST_FB_WRITE
    } draw_state_t;

endpackage

`default_nettype wire

// ==== source/obj_zoom_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface obj_zoom_if;
    import obj_pkg::*;

    logic                      ready;
    logic [4:0]                count;
    // entry n is the source position of the n-th surviving row or column
    logic [TILE_SIZE-1:0]      valid;
    logic [TILE_SIZE-1:0][3:0] index;

    modport calc (
        output ready,
        output count,
        output valid,
        output index
    );

    modport shifter (input valid, input index);

endinterface

`default_nettype wire

// ==== source/obj_zoom_calc.sv ====
`timescale 1ns/1ns
`default_nettype none

module obj_zoom_calc (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic [8:0]  delta,
    obj_zoom_if.calc    map
);
    import obj_pkg::*;

    logic [8:0] accum;
    logic [8:0] accum_next;
    logic [3:0] src;
    logic       running;

    assign accum_next = accum + delta;

    always_ff @(posedge clk) begin
        if (reset) begin
            running   <= 1'b0;
            src       <= '0;
            map.ready <= 1'b0;
            map.count <= '0;
            map.valid <= '0;
        end else if (start) begin
            running   <= 1'b1;
            src       <= '0;
            accum     <= '0;
            map.ready <= 1'b0;
            map.count <= '0;
            map.valid <= '0;
        end else if (running) begin
            src   <= src + 4'd1;
            accum <= accum_next;
            // a carry into bit 8 keeps this source position
            if (accum_next[8] != accum[8]) begin
                map.valid[map.count[3:0]] <= 1'b1;
                map.index[map.count[3:0]] <= src;
                map.count                 <= map.count + 5'd1;
            end
            if (src == 4'(TILE_SIZE - 1)) begin
                running   <= 1'b0;
                map.ready <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/obj_data_shifter.sv ====
`timescale 1ns/1ns
`default_nettype none

module obj_data_shifter (
    input  logic                   clk,
    input  logic                   clear,
    input  logic                   bpp6,
    input  obj_pkg::fb_word_t      rdata,
    input  logic                   rdata_valid,
    output logic                   load_complete,
    input  obj_pkg::coord_t        pos_x,
    input  obj_pkg::coord_t        pos_y,
    input  logic                   flip_x,
    input  logic                   flip_y,
    input  obj_pkg::color_t        color,
    obj_zoom_if.shifter            rows,
    obj_zoom_if.shifter            cols,
    input  logic                   out_read,
    output obj_pkg::fb_word_t      out_data,
    output obj_pkg::fb_be_t        out_be,
    output obj_pkg::fb_word_addr_t out_addr,
    output logic                   out_ready,
    output logic                   out_done
);
    import obj_pkg::*;

    localparam int ROW_PIX = ROW_WORDS * 4;

    typedef logic [ROW_PIX-1:0][5:0] row_buf_t;

    logic [5:0]    pixel [TILE_SIZE*TILE_SIZE];
    row_buf_t      row_data;
    logic [4:0]    beat;
    logic [4:0]    last_beat;
    logic          load_beat;
    logic          need_first_row;
    logic [3:0]    row;
    logic [2:0]    col;

    logic          spr_bpp6;
    logic          spr_flip_x;
    logic          spr_flip_y;
    color_t        spr_color;
    fb_word_addr_t spr_base;
    logic [1:0]    spr_shift;

    fb_word_t      word_next;
    fb_be_t        be_next;
    fb_word_addr_t addr_next;

    // four pixels per 32-bit half, low nibbles and high pairs split apart
    function automatic logic [3:0][5:0] decode_6bpp(input logic [31:0] d);
        logic [3:0][5:0] p;
        p[0] = {d[17:16], d[11:8]};
        p[1] = {d[19:18], d[15:12]};
        p[2] = {d[21:20], d[3:0]};
        p[3] = {d[23:22], d[7:4]};
        return p;
    endfunction

    // gathers the surviving columns of one destination row
    function automatic row_buf_t build_row(input logic [3:0] r);
        row_buf_t   rb;
        logic [3:0] ri;
        logic [3:0] ci;
        int         i;
        rb = '0;
        ri = rows.index[r] ^ {4{spr_flip_y}};
        if (rows.valid[r]) begin
            for (i = 0; i < TILE_SIZE; i++) begin
                if (cols.valid[i]) begin
                    ci = cols.index[i] ^ {4{spr_flip_x}};
                    rb[i + spr_shift] = pixel[{ri, ci}];
                end
            end
        end
        return rb;
    endfunction

    assign last_beat = spr_bpp6 ? 5'(BURST_6BPP - 1) : 5'(BURST_4BPP - 1);
    assign load_beat = rdata_valid & ~clear & ~load_complete;
    assign addr_next = spr_base + {4'd0, row, 4'd0, col};

    always_comb begin
        int k;
        word_next = '0;
        be_next   = '0;
        for (k = 0; k < 4; k++) begin
            if (spr_bpp6) begin
                word_next[16*k +: 16] = {4'd0, spr_color[7:2], row_data[k]};
            end else begin
                word_next[16*k +: 16] = {4'd0, spr_color, row_data[k][3:0]};
            end
            // index 0 is transparent
            be_next[2*k +: 2] = {2{|row_data[k]}};
        end
    end

    // sprite fields follow the inputs until the sequencer leaves idle
    always_ff @(posedge clk) begin
        if (clear) begin
            spr_bpp6   <= bpp6;
            spr_flip_x <= flip_x;
            spr_flip_y <= flip_y;
            spr_color  <= color;
            spr_base   <= {pos_y[7:0], pos_x[8:2]};
            spr_shift  <= pos_x[1:0];
        end
    end

    always_ff @(posedge clk) begin
        logic [3:0][5:0] lo;
        logic [3:0][5:0] hi;
        int              k;
        lo = decode_6bpp(rdata[31:0]);
        hi = decode_6bpp(rdata[63:32]);
        if (load_beat) begin
            if (spr_bpp6) begin
                for (k = 0; k < 4; k++) begin
                    pixel[{beat, 3'(k)}]     <= lo[k];
                    pixel[{beat, 3'(k + 4)}] <= hi[k];
                end
            end else begin
                for (k = 0; k < TILE_SIZE; k++) begin
                    pixel[{beat[3:0], 4'(k)}] <= {2'b00, rdata[4*k +: 4]};
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            beat           <= '0;
            load_complete  <= 1'b0;
            need_first_row <= 1'b0;
            out_ready      <= 1'b0;
            out_done       <= 1'b0;
            row            <= '0;
            col            <= '0;
        end else begin
            if (load_beat) begin
                beat <= beat + 5'd1;
                if (beat == last_beat) begin
                    load_complete  <= 1'b1;
                    need_first_row <= 1'b1;
                end
            end

            if (need_first_row) begin
                row_data       <= build_row(4'd0);
                need_first_row <= 1'b0;
            end else if (load_complete && (!out_ready || (out_read && !out_done))) begin
                out_data  <= word_next;
                out_be    <= be_next;
                out_addr  <= addr_next;
                out_ready <= 1'b1;
                if (col == 3'(ROW_WORDS - 1)) begin
                    col      <= '0;
                    row      <= row + 4'd1;
                    row_data <= build_row(row + 4'd1);
                    if (row == 4'(TILE_SIZE - 1) || !rows.valid[row + 4'd1]) begin
                        out_done <= 1'b1;
                    end
                end else begin
                    col      <= col + 3'd1;
                    row_data <= row_data >> 24;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/obj_draw_seq.sv ====
`timescale 1ns/1ns
`default_nettype none

module obj_draw_seq #(
    parameter obj_pkg::mem_addr_t DATA_BASE = obj_pkg::OBJ_DATA_BASE,
    parameter obj_pkg::mem_addr_t FB_BASE   = obj_pkg::OBJ_FB_BASE
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  obj_pkg::tile_code_t    tile_code,
    input  obj_pkg::coord_t        pos_x,
    input  obj_pkg::coord_t        pos_y,
    input  obj_pkg::zoom_t         x_zoom,
    input  obj_pkg::zoom_t         y_zoom,
    input  logic                   bpp6,
    output logic                   busy,
    output logic                   done,
    output logic                   row_start,
    output logic                   col_start,
    output logic [8:0]             row_delta,
    output logic [8:0]             col_delta,
    input  logic                   rows_ready,
    input  logic                   cols_ready,
    input  logic [4:0]             row_count,
    output logic                   shifter_clear,
    input  logic                   load_complete,
    input  logic                   out_ready,
    input  logic                   out_done,
    output logic                   out_read,
    input  obj_pkg::fb_word_addr_t out_addr,
    input  obj_pkg::fb_word_t      out_data,
    input  obj_pkg::fb_be_t        out_be,
    output logic                   rom_read,
    output obj_pkg::mem_addr_t     rom_addr,
    output obj_pkg::burst_len_t    rom_burstcnt,
    output logic                   fb_write,
    output obj_pkg::mem_addr_t     fb_addr,
    output obj_pkg::fb_word_t      fb_data,
    output obj_pkg::fb_be_t        fb_be,
    input  logic                   fb_busy
);
    import obj_pkg::*;

    draw_state_t state;

    tile_code_t  req_code;
    coord_t      req_x;
    coord_t      req_y;
    zoom_t       req_x_zoom;
    zoom_t       req_y_zoom;
    logic        req_bpp6;

    logic [6:0]  words_left;
    logic        last_word;

    assign shifter_clear = (state == ST_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            busy      <= 1'b0;
            done      <= 1'b0;
            row_start <= 1'b0;
            col_start <= 1'b0;
            rom_read  <= 1'b0;
            out_read  <= 1'b0;
            fb_write  <= 1'b0;
        end else begin
            done      <= 1'b0;
            row_start <= 1'b0;
            col_start <= 1'b0;
            rom_read  <= 1'b0;
            out_read  <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (start) begin
                        req_code   <= tile_code;
                        req_x      <= pos_x;
                        req_y      <= pos_y;
                        req_x_zoom <= x_zoom;
                        req_y_zoom <= y_zoom;
                        req_bpp6   <= bpp6;
                        busy       <= 1'b1;
                        state      <= ST_CHECK;
                    end
                end

                ST_CHECK: begin
                    if (req_code == '0 || req_x > MAX_X || req_y > MAX_Y) begin
                        done  <= 1'b1;
                        busy  <= 1'b0;
                        state <= ST_IDLE;
                    end else begin
                        row_delta <= 9'h100 - {1'b0, req_y_zoom};
                        col_delta <= 9'h100 - {1'b0, req_x_zoom};
                        row_start <= 1'b1;
                        col_start <= 1'b1;
                        state     <= ST_ZOOM;
                    end
                end

                // ready is still stale while the start pulse is out
                ST_ZOOM: begin
                    if (!row_start && rows_ready && cols_ready) begin
                        rom_read     <= 1'b1;
                        rom_burstcnt <= req_bpp6 ? burst_len_t'(BURST_6BPP)
                                                 : burst_len_t'(BURST_4BPP);
                        rom_addr     <= DATA_BASE
                                        + (mem_addr_t'(req_code) << (req_bpp6 ? 8 : 7));
                        words_left   <= (row_count == 5'd0) ? 7'(ROW_WORDS)
                                                            : 7'(ROW_WORDS * row_count);
                        state        <= ST_LOAD;
                    end
                end

                ST_LOAD: begin
                    if (load_complete) begin
                        state <= ST_FB_LOAD;
                    end
                end

                ST_FB_LOAD: begin
                    if (out_ready) begin
                        fb_write   <= 1'b1;
                        fb_addr    <= FB_BASE + {14'd0, out_addr, 3'd0};
                        fb_data    <= out_data;
                        fb_be      <= out_be;
                        out_read   <= 1'b1;
                        last_word  <= out_done || (words_left == 7'd1);
                        words_left <= words_left - 7'd1;
                        state      <= ST_FB_WRITE;
                    end
                end

                ST_FB_WRITE: begin
                    if (!fb_busy) begin
                        fb_write <= 1'b0;
                        if (last_word) begin
                            done  <= 1'b1;
                            busy  <= 1'b0;
                            state <= ST_IDLE;
                        end else begin
                            state <= ST_FB_LOAD;
                        end
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/obj_draw_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module obj_draw_top #(
    parameter obj_pkg::mem_addr_t DATA_BASE = obj_pkg::OBJ_DATA_BASE,
    parameter obj_pkg::mem_addr_t FB_BASE   = obj_pkg::OBJ_FB_BASE
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  obj_pkg::tile_code_t tile_code,
    input  obj_pkg::coord_t     pos_x,
    input  obj_pkg::coord_t     pos_y,
    input  obj_pkg::zoom_t      x_zoom,
    input  obj_pkg::zoom_t      y_zoom,
    input  logic                flip_x,
    input  logic                flip_y,
    input  obj_pkg::color_t     color,
    input  logic                bpp6,
    output logic                busy,
    output logic                done,
    output logic                rom_read,
    output obj_pkg::mem_addr_t  rom_addr,
    output obj_pkg::burst_len_t rom_burstcnt,
    input  obj_pkg::fb_word_t   rom_rdata,
    input  logic                rom_rdata_valid,
    output logic                fb_write,
    output obj_pkg::mem_addr_t  fb_addr,
    output obj_pkg::fb_word_t   fb_data,
    output obj_pkg::fb_be_t     fb_be,
    input  logic                fb_busy
);
    import obj_pkg::*;

    obj_zoom_if row_map ();
    obj_zoom_if col_map ();

    logic          row_start;
    logic          col_start;
    logic [8:0]    row_delta;
    logic [8:0]    col_delta;
    logic          shifter_clear;
    logic          load_complete;
    logic          out_ready;
    logic          out_done;
    logic          out_read;
    fb_word_addr_t out_addr;
    fb_word_t      out_data;
    fb_be_t        out_be;

    obj_draw_seq #(
        .DATA_BASE (DATA_BASE),
        .FB_BASE   (FB_BASE)
    ) u_seq (
        .clk, .reset, .start, .tile_code, .pos_x, .pos_y, .x_zoom, .y_zoom, .bpp6,
        .busy, .done, .row_start, .col_start, .row_delta, .col_delta,
        .rows_ready (row_map.ready),
        .cols_ready (col_map.ready),
        .row_count  (row_map.count),
        .shifter_clear, .load_complete, .out_ready, .out_done, .out_read,
        .out_addr, .out_data, .out_be,
        .rom_read, .rom_addr, .rom_burstcnt,
        .fb_write, .fb_addr, .fb_data, .fb_be, .fb_busy
    );

    obj_zoom_calc u_row_calc (
        .clk, .reset,
        .start (row_start),
        .delta (row_delta),
        .map   (row_map.calc)
    );

    obj_zoom_calc u_col_calc (
        .clk, .reset,
        .start (col_start),
        .delta (col_delta),
        .map   (col_map.calc)
    );

    obj_data_shifter u_shifter (
        .clk,
        .clear       (shifter_clear),
        .bpp6,
        .rdata       (rom_rdata),
        .rdata_valid (rom_rdata_valid),
        .load_complete,
        .pos_x, .pos_y, .flip_x, .flip_y, .color,
        .rows        (row_map.shifter),
        .cols        (col_map.shifter),
        .out_read, .out_data, .out_be, .out_addr, .out_ready, .out_done
    );

endmodule

`default_nettype wire

// ==== verification/obj_draw_model.svh ====
`ifndef OBJ_DRAW_MODEL_SVH
`define OBJ_DRAW_MODEL_SVH

// memory map handed to the DUT
localparam mem_addr_t ROM_BASE = 32'h0020_0000;
localparam mem_addr_t FB_BASE  = 32'h0400_0000;

// expected traffic of the sprite in flight
logic       exp_rom_read;
mem_addr_t  exp_rom_addr;
burst_len_t exp_burstcnt;
mem_addr_t  exp_addr [$];
fb_word_t   exp_data [$];
fb_be_t     exp_be   [$];

// tile ROM content is a hash of the full byte address, with plenty of zero pixels
function automatic fb_word_t rom_word(input mem_addr_t addr);
    logic [31:0] h0;
    logic [31:0] h1;
    logic [31:0] h2;
    h0 = addr * 32'h9e37_79b1;
    h0 = h0 ^ (h0 >> 15);
    h1 = (h0 ^ 32'h5bd1_e995) * 32'h85eb_ca6b;
    h1 = h1 ^ (h1 >> 13);
    h2 = (h1 + addr) * 32'hc2b2_ae35;
    return {h0 & h2, h1 & (h2 ^ h0)};
endfunction

// surviving source positions for one zoom factor, returns their count
function automatic int zoom_map(input zoom_t zoom, output logic [15:0][3:0] idx);
    logic [8:0] delta;
    logic [8:0] acc;
    logic [8:0] nxt;
    int         n;
    int         s;
    delta = 9'h100 - {1'b0, zoom};
    acc   = '0;
    idx   = '0;
    n     = 0;
    for (s = 0; s < TILE_SIZE; s++) begin
        nxt = acc + delta;
        if (nxt[8] != acc[8]) begin
            idx[n] = 4'(s);
            n++;
        end
        acc = nxt;
    end
    return n;
endfunction

// pixel index at source row r, column c of the tile at base
function automatic logic [5:0] tile_pixel(input mem_addr_t base, input logic b6,
                                          input logic [3:0] r, input logic [3:0] c);
    fb_word_t    w;
    logic [31:0] d;
    int          m;
    logic [5:0]  p;
    if (b6) begin
        // two beats per row, four pixels in each 32-bit half
        w = rom_word(base + 8 * (2 * r + c[3]));
        d = w[32 * c[2] +: 32];
        m = c[1:0];
        // low nibbles sit at 11:8, 15:12, 3:0, 7:4
        p = {d[16 + 2 * m +: 2], d[4 * (m ^ 2) +: 4]};
    end else begin
        w = rom_word(base + 8 * r);
        p = {2'b00, w[4 * c +: 4]};
    end
    return p;
endfunction

function automatic void build_expected(input tile_code_t code, input coord_t px,
                                       input coord_t py, input zoom_t xz, input zoom_t yz,
                                       input logic fx, input logic fy, input color_t bank,
                                       input logic b6);
    logic [15:0][3:0] ridx;
    logic [15:0][3:0] cidx;
    logic [5:0]       line [20];
    logic [5:0]       p;
    fb_word_t         data;
    fb_be_t           be;
    fb_word_addr_t    waddr;
    mem_addr_t        base;
    int               nr;
    int               nc;
    int               r;
    int               i;
    int               w;
    int               k;
    exp_addr.delete();
    exp_data.delete();
    exp_be.delete();
    exp_rom_read = 1'b0;
    if (code != 0 && px <= MAX_X && py <= MAX_Y) begin
        base         = ROM_BASE + mem_addr_t'(code) * (b6 ? BURST_6BPP : BURST_4BPP) * 8;
        exp_rom_read = 1'b1;
        exp_rom_addr = base;
        exp_burstcnt = burst_len_t'(b6 ? BURST_6BPP : BURST_4BPP);
        nr = zoom_map(yz, ridx);
        nc = zoom_map(xz, cidx);
        // zoomed down to nothing still writes one empty row
        for (r = 0; r < (nr == 0 ? 1 : nr); r++) begin
            for (i = 0; i < 20; i++) begin
                line[i] = '0;
            end
            if (r < nr) begin
                for (i = 0; i < nc; i++) begin
                    line[i + px[1:0]] = tile_pixel(base, b6, ridx[r] ^ {4{fy}},
                                                   cidx[i] ^ {4{fx}});
                end
            end
            for (w = 0; w < ROW_WORDS; w++) begin
                data = '0;
                be   = '0;
                for (k = 0; k < 4; k++) begin
                    p = line[4 * w + k];
                    data[16 * k +: 16] = b6 ? {4'd0, bank[7:2], p} : {4'd0, bank, p[3:0]};
                    be[2 * k +: 2]     = (p != 0) ? 2'b11 : 2'b00;
                end
                waddr = {py[7:0], px[8:2]} + fb_word_addr_t'(r * 128 + w);
                exp_addr.push_back(FB_BASE + {waddr, 3'b000});
                exp_data.push_back(data);
                exp_be.push_back(be);
            end
        end
    end
endfunction

`endif

// ==== verification/obj_draw_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module obj_draw_tb;
    import obj_pkg::*;

    localparam int     CLK_PERIOD    = 4;
    localparam integer SEED          = 32'h4892_727c;
    localparam int     NUM_DIRECTED  = 9;
    localparam int     NUM_CALM      = 8;
    localparam int     NUM_STRESS    = 30;
    localparam int     NUM_SPRITES   = NUM_DIRECTED + NUM_CALM + NUM_STRESS;
    // zoom, a gapped 32-beat burst and 80 stalled writes stay well inside this
    localparam int     SPRITE_CYCLES = 2000;
    localparam int     TIMEOUT_NS    = (NUM_SPRITES * SPRITE_CYCLES + 20) * CLK_PERIOD;

    logic       clk = 1'b0;
    logic       reset;
    logic       start;
    tile_code_t tile_code;
    coord_t     pos_x;
    coord_t     pos_y;
    zoom_t      x_zoom;
    zoom_t      y_zoom;
    logic       flip_x;
    logic       flip_y;
    color_t     color;
    logic       bpp6;
    logic       busy;
    logic       done;
    logic       rom_read;
    mem_addr_t  rom_addr;
    burst_len_t rom_burstcnt;
    fb_word_t   rom_rdata;
    logic       rom_rdata_valid;
    logic       fb_write;
    mem_addr_t  fb_addr;
    fb_word_t   fb_data;
    fb_be_t     fb_be;
    logic       fb_busy;

    `include "obj_draw_model.svh"

    integer seed      = SEED;
    integer gap_seed  = SEED + 1;
    integer busy_seed = SEED + 2;
    logic   stress;
    logic   in_flight;
    int     mismatches;
    int     other_errors;
    int     writes_checked;
    int     sprites_checked;
    int     write_idx;
    int     rom_reads;

    obj_draw_top #(
        .DATA_BASE (ROM_BASE),
        .FB_BASE   (FB_BASE)
    ) u_obj_draw_top (
        .clk, .reset, .start, .tile_code, .pos_x, .pos_y, .x_zoom, .y_zoom,
        .flip_x, .flip_y, .color, .bpp6, .busy, .done,
        .rom_read, .rom_addr, .rom_burstcnt, .rom_rdata, .rom_rdata_valid,
        .fb_write, .fb_addr, .fb_data, .fb_be, .fb_busy
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_and_finish;
        $display("errors: %0d mismatches, %0d other (%0d sprites, %0d writes checked)",
                 mismatches, other_errors, sprites_checked, writes_checked);
        if (mismatches == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    task automatic draw_sprite(input tile_code_t code, input coord_t px, input coord_t py,
                               input zoom_t xz, input zoom_t yz, input logic fx,
                               input logic fy, input color_t bank, input logic b6);
        int target;
        target = sprites_checked + 1;
        build_expected(code, px, py, xz, yz, fx, fy, bank, b6);
        tile_code <= code;
        pos_x     <= px;
        pos_y     <= py;
        x_zoom    <= xz;
        y_zoom    <= yz;
        flip_x    <= fx;
        flip_y    <= fy;
        color     <= bank;
        bpp6      <= b6;
        start     <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        // the checker counts the sprite off when done shows up
        wait (sprites_checked == target);
    endtask

    task automatic draw_random_sprite;
        tile_code_t code;
        coord_t     px;
        coord_t     py;
        zoom_t      xz;
        zoom_t      yz;
        logic [2:0] pick;
        code = tile_code_t'($random(seed));
        // some positions land past the bounds on purpose
        px   = coord_t'($random(seed)) & 12'h1ff;
        py   = coord_t'($random(seed)) & 12'h0ff;
        xz   = zoom_t'($random(seed));
        yz   = zoom_t'($random(seed));
        pick = 3'($random(seed));
        if (($random(seed) & 3) == 0) begin
            xz = '0;
        end
        if (($random(seed) & 3) == 0) begin
            yz = '0;
        end
        draw_sprite(code, px, py, xz, yz, pick[0], pick[1], color_t'($random(seed)), pick[2]);
    endtask

    task automatic check_write(input int idx);
        assert (fb_addr == exp_addr[idx]) else begin
            mismatches++;
            $display("mismatch fb_addr: got %h expected %h (sprite %0d word %0d)",
                     fb_addr, exp_addr[idx], sprites_checked, idx);
        end
        assert (fb_data == exp_data[idx]) else begin
            mismatches++;
            $display("mismatch fb_data: got %h expected %h (sprite %0d word %0d)",
                     fb_data, exp_data[idx], sprites_checked, idx);
        end
        assert (fb_be == exp_be[idx]) else begin
            mismatches++;
            $display("mismatch fb_be: got %h expected %h (sprite %0d word %0d)",
                     fb_be, exp_be[idx], sprites_checked, idx);
        end
        writes_checked++;
    endtask

    // values read at the edge are the ones the DUT samples there
    always @(posedge clk) begin
        if (!reset) begin
            // busy rises after the accepted start and falls together with done
            assert (busy == (in_flight && !done)) else begin
                mismatches++;
                $display("mismatch busy: got %h expected %h (sprite %0d)",
                         busy, in_flight && !done, sprites_checked);
            end
            if (start) begin
                in_flight = 1'b1;
            end
            if (rom_read) begin
                rom_reads++;
                assert (exp_rom_read) else begin
                    other_errors++;
                    $display("sprite %0d should be rejected but read the ROM", sprites_checked);
                end
                assert (!exp_rom_read || rom_addr == exp_rom_addr) else begin
                    mismatches++;
                    $display("mismatch rom_addr: got %h expected %h", rom_addr, exp_rom_addr);
                end
                assert (!exp_rom_read || rom_burstcnt == exp_burstcnt) else begin
                    mismatches++;
                    $display("mismatch rom_burstcnt: got %h expected %h",
                             rom_burstcnt, exp_burstcnt);
                end
            end
            if (fb_write && !fb_busy) begin
                assert (write_idx < exp_addr.size()) else begin
                    other_errors++;
                    $display("sprite %0d wrote more than its %0d expected words",
                             sprites_checked, exp_addr.size());
                end
                if (write_idx < exp_addr.size()) begin
                    check_write(write_idx);
                end
                write_idx++;
            end
            if (done) begin
                assert (write_idx == exp_addr.size()) else begin
                    other_errors++;
                    $display("sprite %0d finished after %0d writes instead of %0d",
                             sprites_checked, write_idx, exp_addr.size());
                end
                assert (rom_reads == (exp_rom_read ? 1 : 0)) else begin
                    other_errors++;
                    $display("sprite %0d issued %0d ROM reads", sprites_checked, rom_reads);
                end
                write_idx = 0;
                rom_reads = 0;
                in_flight = 1'b0;
                sprites_checked++;
            end
        end
    end

    initial begin : rom_responder
        mem_addr_t burst_addr;
        int        beats;
        int        gap;
        int        i;
        rom_rdata       = '0;
        rom_rdata_valid = 1'b0;
        forever begin
            @(posedge clk);
            if (rom_read) begin
                burst_addr = rom_addr;
                beats      = rom_burstcnt;
                for (i = 0; i < beats; i++) begin
                    gap = stress ? ($random(gap_seed) & 3) : 0;
                    repeat (gap) begin
                        rom_rdata_valid <= 1'b0;
                        @(posedge clk);
                    end
                    rom_rdata_valid <= 1'b1;
                    rom_rdata       <= rom_word(burst_addr + 8 * i);
                    @(posedge clk);
                end
                rom_rdata_valid <= 1'b0;
            end
        end
    end

    initial begin : fb_busy_gen
        fb_busy = 1'b0;
        forever begin
            @(posedge clk);
            fb_busy <= stress && (($random(busy_seed) & 3) == 0);
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        other_errors++;
        $display("timeout: sprites still pending after %0d ns", TIMEOUT_NS);
        report_and_finish();
    end

    initial begin : stimulus
        int n;
        reset           = 1'b1;
        start           = 1'b0;
        tile_code       = '0;
        pos_x           = '0;
        pos_y           = '0;
        x_zoom          = '0;
        y_zoom          = '0;
        flip_x          = 1'b0;
        flip_y          = 1'b0;
        color           = '0;
        bpp6            = 1'b0;
        stress          = 1'b0;
        in_flight       = 1'b0;
        mismatches      = 0;
        other_errors    = 0;
        writes_checked  = 0;
        sprites_checked = 0;
        write_idx       = 0;
        rom_reads       = 0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // full size 4 bpp, word aligned and shifted
        draw_sprite(13'h0123, 12'd100, 12'd50, 8'd0, 8'd0, 1'b0, 1'b0, 8'ha5, 1'b0);
        draw_sprite(13'h1abc, 12'd37, 12'd200, 8'd0, 8'd0, 1'b0, 1'b0, 8'h5e, 1'b0);
        // 6 bpp keeps only the bank's top bits
        draw_sprite(13'h0456, 12'd201, 12'd17, 8'd0, 8'd0, 1'b0, 1'b0, 8'hb7, 1'b1);
        draw_sprite(13'h0789, 12'd62, 12'd90, 8'd96, 8'd160, 1'b1, 1'b0, 8'h12, 1'b0);
        draw_sprite(13'h0a0b, 12'd143, 12'd31, 8'd200, 8'd48, 1'b0, 1'b1, 8'hc3, 1'b1);
        // zoomed to nothing at the last legal position
        draw_sprite(13'h00ff, 12'd480, 12'd240, 8'd255, 8'd250, 1'b1, 1'b1, 8'h7f, 1'b0);
        draw_sprite(13'h0000, 12'd10, 12'd10, 8'd0, 8'd0, 1'b0, 1'b0, 8'h11, 1'b0);
        draw_sprite(13'h0100, 12'd481, 12'd10, 8'd0, 8'd0, 1'b0, 1'b0, 8'h22, 1'b1);
        draw_sprite(13'h0100, 12'd10, 12'd241, 8'd0, 8'd0, 1'b0, 1'b0, 8'h33, 1'b0);

        for (n = 0; n < NUM_CALM; n++) begin
            draw_random_sprite();
        end
        stress <= 1'b1;
        for (n = 0; n < NUM_STRESS; n++) begin
            draw_random_sprite();
        end
        report_and_finish();
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verification
source/obj_pkg.sv
source/obj_zoom_if.sv
source/obj_zoom_calc.sv
source/obj_data_shifter.sv
source/obj_draw_seq.sv
source/obj_draw_top.sv
verification/obj_draw_tb.sv

// ==== Bender.yml ====
package:
  name: obj_draw

sources:
  - source/obj_pkg.sv
  - source/obj_zoom_if.sv
  - source/obj_zoom_calc.sv
  - source/obj_data_shifter.sv
  - source/obj_draw_seq.sv
  - source/obj_draw_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/obj_draw_tb.sv
